// File: logic/sg_dma_pkg.sv
/* sg dma shared types
   descriptor layout, register word map, engine states and the
   command and status bundles between register slave and engine */
package sg_dma_pkg;

   localparam int SLOT_NUM   = 4;                   // history depth
   localparam int DESC_WORDS = 4;                   // words per descriptor
   localparam int SLOT_IDX_W = $clog2(SLOT_NUM);
   localparam int WORD_IDX_W = $clog2(DESC_WORDS);

   // one descriptor as it sits in memory, word 0 first
   typedef struct packed {
      logic [7:0]  state;   // bit 0 stop
      logic [15:0] desc;    // length / control
      logic [31:3] addr;    // buffer address
      logic [31:3] next;    // next descriptor, zero ends chain
   } sg_desc_t;

   // register word index, wbs_adr_i[6:2]
   typedef enum logic [4:0] {
      REG_CCR      = 5'h00,
      REG_CSR      = 5'h01,
      REG_DAR      = 5'h02,
      REG_NDAR     = 5'h03,
      REG_S0_STATE = 5'h04,
      REG_S0_DESC  = 5'h05,
      REG_S0_ADDR  = 5'h06,
      REG_S0_NEXT  = 5'h07,
      REG_S1_STATE = 5'h08,
      REG_S1_DESC  = 5'h09,
      REG_S1_ADDR  = 5'h0a,
      REG_S1_NEXT  = 5'h0b,
      REG_S2_STATE = 5'h0c,
      REG_S2_DESC  = 5'h0d,
      REG_S2_ADDR  = 5'h0e,
      REG_S2_NEXT  = 5'h0f,
      REG_S3_STATE = 5'h10,
      REG_S3_DESC  = 5'h11,
      REG_S3_ADDR  = 5'h12,
      REG_S3_NEXT  = 5'h13,
      REG_FIRST    = 5'h14,
      REG_LAST     = 5'h15,
      REG_NEXT     = 5'h16
   } csr_reg_e;

   typedef enum logic [1:0] {
      IDLE,
      FETCH,
      STORE,
      HALT
   } chain_state_e;

   typedef struct packed {
      logic        enable;
      logic        resume;
      logic [31:3] ndar;
      logic        ndar_dirty;  // ndar written since last start
      logic        int_clear;   // one cycle pulse
   } ctrl_cmd_t;

   typedef struct packed {
      logic                    busy;
      logic                    irq;
      logic [31:3]             dar;
      logic [31:3]             first;
      logic [31:3]             last;
      logic [31:3]             next_desc;
      logic                    resume_clear;
      logic                    ndar_dirty_clear;
      sg_desc_t [SLOT_NUM-1:0] slots;
   } chain_stat_t;

endpackage

// File: logic/dma_csr_slave.sv
/* dma register slave
   wishbone classic slave holding control and ndar, with a plain
   read decoder over engine status and the descriptor history */
module dma_csr_slave (
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   input  logic                    wbs_cyc_i,
   input  logic                    wbs_stb_i,
   input  logic                    wbs_we_i,
   input  logic [3:0]              wbs_sel_i,
   input  logic [31:0]             wbs_adr_i,
   input  logic [31:0]             wbs_dat_i,
   output logic [31:0]             wbs_dat_o,
   output logic                    wbs_ack_o,
   output logic                    wbs_err_o,
   output logic                    wbs_rty_o,
   input  sg_dma_pkg::chain_stat_t stat_i,
   output sg_dma_pkg::ctrl_cmd_t   cmd_o
);
   import sg_dma_pkg::*;

   logic        req;
   logic        sel_full;
   logic        wr_en;
   logic        ccr_we;
   logic        ndar_we;
   csr_reg_e    reg_idx;
   logic [1:0]  slot_n;
   sg_desc_t    slot_sel;
   logic        enable_q;
   logic        resume_q;
   logic        int_clear_q;
   logic        ndar_dirty_q;
   logic [31:3] ndar_q;

   // only a new request while no response is on the bus
   assign req       = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o & ~wbs_err_o;
   assign sel_full  = (wbs_sel_i == 4'b1111);
   assign wr_en     = req & sel_full & wbs_we_i;
   assign reg_idx   = csr_reg_e'(wbs_adr_i[6:2]);
   assign ccr_we    = wr_en && (reg_idx == REG_CCR);
   assign ndar_we   = wr_en && (reg_idx == REG_NDAR) && !enable_q; // locked while enabled
   assign wbs_rty_o = 1'b0;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbs_ack_o <= 1'b0;
         wbs_err_o <= 1'b0;
      end else begin
         wbs_ack_o <= req & sel_full;
         wbs_err_o <= req & ~sel_full;   // partial select not supported
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         enable_q    <= 1'b0;
         resume_q    <= 1'b0;
         int_clear_q <= 1'b0;
      end else begin
         int_clear_q <= 1'b0;
         if (ccr_we) begin
            enable_q    <= wbs_dat_i[1];
            resume_q    <= wbs_dat_i[0];
            int_clear_q <= wbs_dat_i[2];
         end else if (stat_i.resume_clear) begin
            resume_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ndar_q       <= '0;
         ndar_dirty_q <= 1'b0;
      end else if (ndar_we) begin
         ndar_q       <= wbs_dat_i[31:3];
         ndar_dirty_q <= 1'b1;
      end else if (stat_i.ndar_dirty_clear) begin
         ndar_dirty_q <= 1'b0;          // engine took it
      end
   end

   // slot n lives at word 4+4n, so bits 6:4 hold n+1
   assign slot_n   = 2'(wbs_adr_i[6:4] - 3'd1);
   assign slot_sel = stat_i.slots[slot_n];

   always_comb begin
      case (reg_idx)
         REG_CCR:   wbs_dat_o = {30'h0, enable_q, resume_q};
         REG_CSR:   wbs_dat_o = {30'h0, stat_i.busy, stat_i.irq};
         REG_DAR:   wbs_dat_o = {stat_i.dar, 3'b000};
         REG_NDAR:  wbs_dat_o = {ndar_q, 3'b000};
         REG_S0_STATE, REG_S1_STATE, REG_S2_STATE, REG_S3_STATE:
            wbs_dat_o = {24'h0, slot_sel.state};
         REG_S0_DESC, REG_S1_DESC, REG_S2_DESC, REG_S3_DESC:
            wbs_dat_o = {16'h0, slot_sel.desc};
         REG_S0_ADDR, REG_S1_ADDR, REG_S2_ADDR, REG_S3_ADDR:
            wbs_dat_o = {slot_sel.addr, 3'b000};
         REG_S0_NEXT, REG_S1_NEXT, REG_S2_NEXT, REG_S3_NEXT:
            wbs_dat_o = {slot_sel.next, 3'b000};
         REG_FIRST: wbs_dat_o = {stat_i.first, 3'b000};
         REG_LAST:  wbs_dat_o = {stat_i.last, 3'b000};
         REG_NEXT:  wbs_dat_o = {stat_i.next_desc, 3'b000};
         default:   wbs_dat_o = 32'h0;
      endcase
   end

   assign cmd_o.enable     = enable_q;
   assign cmd_o.resume     = resume_q;
   assign cmd_o.ndar       = ndar_q;
   assign cmd_o.ndar_dirty = ndar_dirty_q;
   assign cmd_o.int_clear  = int_clear_q;

   a_ack_err_excl: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      !(wbs_ack_o && wbs_err_o));

endmodule

// File: logic/sg_desc_fetch.sv
/* descriptor fetcher
   wishbone master reading the four words of one descriptor */
module sg_desc_fetch (
   input  logic                 wb_clk_i,
   input  logic                 wb_rst_i,
   input  logic                 start_i,
   input  logic [31:3]          addr_i,
   output logic                 done_o,
   output logic                 fetch_err_o,
   output logic                 busy_o,
   output sg_dma_pkg::sg_desc_t desc_o,
   output logic                 wbm_cyc_o,
   output logic                 wbm_stb_o,
   output logic                 wbm_we_o,
   output logic [3:0]           wbm_sel_o,
   output logic [31:0]          wbm_adr_o,
   input  logic [31:0]          wbm_dat_i,
   input  logic                 wbm_ack_i,
   input  logic                 wbm_err_i
);
   import sg_dma_pkg::*;

   logic [31:3]           base_q;
   logic [WORD_IDX_W-1:0] word_cnt_q;
   logic                  busy_q;
   logic                  cyc_q;
   logic                  last_word;
   sg_desc_t              desc_q;

   assign last_word = (word_cnt_q == WORD_IDX_W'(DESC_WORDS - 1));

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         base_q      <= '0;
         word_cnt_q  <= '0;
         busy_q      <= 1'b0;
         cyc_q       <= 1'b0;
         done_o      <= 1'b0;
         fetch_err_o <= 1'b0;
      end else begin
         done_o      <= 1'b0;
         fetch_err_o <= 1'b0;
         if (start_i && !busy_q) begin
            base_q     <= addr_i;
            word_cnt_q <= '0;
            busy_q     <= 1'b1;
            cyc_q      <= 1'b1;
         end else if (cyc_q && wbm_err_i) begin
            cyc_q       <= 1'b0;     // abort, rest of descriptor dropped
            busy_q      <= 1'b0;
            done_o      <= 1'b1;
            fetch_err_o <= 1'b1;
         end else if (cyc_q && wbm_ack_i) begin
            cyc_q <= 1'b0;           // bus idle one cycle between words
            if (last_word) begin
               busy_q <= 1'b0;
               done_o <= 1'b1;
            end else begin
               word_cnt_q <= word_cnt_q + 1'b1;
            end
         end else if (busy_q && !cyc_q) begin
            cyc_q <= 1'b1;           // next word
         end
      end
   end

   // word order follows the memory layout of sg_desc_t
   always_ff @(posedge wb_clk_i) begin
      if (cyc_q && wbm_ack_i) begin
         case (word_cnt_q)
            0:       desc_q.state <= wbm_dat_i[7:0];
            1:       desc_q.desc  <= wbm_dat_i[15:0];
            2:       desc_q.addr  <= wbm_dat_i[31:3];
            default: desc_q.next  <= wbm_dat_i[31:3];
         endcase
      end
   end

   assign wbm_cyc_o = cyc_q;
   assign wbm_stb_o = cyc_q;
   assign wbm_we_o  = 1'b0;          // reads only
   assign wbm_sel_o = 4'b1111;
   assign wbm_adr_o = {base_q, 3'b000} + (32'(word_cnt_q) << 2);
   assign busy_o    = busy_q;
   assign desc_o    = desc_q;

   // controller must wait for done before the next start
   a_no_start_busy: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      start_i |-> !busy_q);

endmodule

// File: logic/sg_chain_ctrl.sv
/* chain controller
   walks the descriptor chain, keeps the last four descriptors
   and raises irq when the chain stops */
module sg_chain_ctrl (
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   input  sg_dma_pkg::ctrl_cmd_t   cmd_i,
   output sg_dma_pkg::chain_stat_t stat_o,
   output logic                    start_o,
   output logic [31:3]             addr_o,
   input  logic                    done_i,
   input  logic                    fetch_err_i,
   input  sg_dma_pkg::sg_desc_t    desc_i
);
   import sg_dma_pkg::*;

   chain_state_e            state_q;
   logic [31:3]             dar_q;
   logic [31:3]             first_q;
   logic [31:3]             last_q;
   logic [31:3]             next_desc_q;
   logic [SLOT_IDX_W-1:0]   slot_ptr_q;
   sg_desc_t [SLOT_NUM-1:0] slots_q;
   logic                    irq_q;
   logic                    resume_clear_q;
   logic                    ndar_dirty_clear_q;
   logic                    chain_end;

   // fetcher holds desc_i stable until the next start
   assign chain_end = desc_i.state[0] || (desc_i.next == '0);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q            <= IDLE;
         dar_q              <= '0;
         first_q            <= '0;
         last_q             <= '0;
         next_desc_q        <= '0;
         slot_ptr_q         <= '0;
         slots_q            <= '0;
         irq_q              <= 1'b0;
         start_o            <= 1'b0;
         resume_clear_q     <= 1'b0;
         ndar_dirty_clear_q <= 1'b0;
      end else begin
         start_o            <= 1'b0;
         resume_clear_q     <= 1'b0;
         ndar_dirty_clear_q <= 1'b0;
         if (cmd_i.int_clear)
            irq_q <= 1'b0;           // a halt in the same cycle wins below
         case (state_q)
            IDLE: begin
               if (cmd_i.enable && cmd_i.ndar_dirty) begin
                  dar_q              <= cmd_i.ndar;
                  first_q            <= cmd_i.ndar;
                  ndar_dirty_clear_q <= 1'b1;
                  start_o            <= 1'b1;
                  state_q            <= FETCH;
               end
            end
            FETCH: begin
               if (done_i && fetch_err_i) begin
                  irq_q   <= 1'b1;
                  state_q <= HALT;
               end else if (done_i) begin
                  state_q <= STORE;
               end
            end
            STORE: begin
               slots_q[slot_ptr_q] <= desc_i;
               slot_ptr_q          <= slot_ptr_q + 1'b1;   // round robin
               last_q              <= dar_q;
               next_desc_q         <= desc_i.next;
               if (!cmd_i.enable) begin
                  state_q <= IDLE;
               end else if (chain_end) begin
                  irq_q   <= 1'b1;
                  state_q <= HALT;
               end else begin
                  dar_q   <= desc_i.next;
                  start_o <= 1'b1;
                  state_q <= FETCH;
               end
            end
            HALT: begin
               if (!cmd_i.enable) begin
                  state_q <= IDLE;
               end else if (cmd_i.resume) begin
                  resume_clear_q <= 1'b1;
                  dar_q          <= next_desc_q;  // pick up where the chain stopped
                  start_o        <= 1'b1;
                  state_q        <= FETCH;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   assign addr_o                  = dar_q;
   assign stat_o.busy             = (state_q == FETCH) || (state_q == STORE);
   assign stat_o.irq              = irq_q;
   assign stat_o.dar              = dar_q;
   assign stat_o.first            = first_q;
   assign stat_o.last             = last_q;
   assign stat_o.next_desc        = next_desc_q;
   assign stat_o.resume_clear     = resume_clear_q;
   assign stat_o.ndar_dirty_clear = ndar_dirty_clear_q;
   assign stat_o.slots            = slots_q;

   // a held int_clear from the slave would wipe the irq of a later halt
   a_clear_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      cmd_i.int_clear |=> !cmd_i.int_clear);

endmodule

// File: logic/sg_dma_top.sv
/* sg dma engine top
   register slave, chain controller and descriptor fetcher */
module sg_dma_top (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        wbs_cyc_i,
   input  logic        wbs_stb_i,
   input  logic        wbs_we_i,
   input  logic [3:0]  wbs_sel_i,
   input  logic [31:0] wbs_adr_i,
   input  logic [31:0] wbs_dat_i,
   output logic [31:0] wbs_dat_o,
   output logic        wbs_ack_o,
   output logic        wbs_err_o,
   output logic        wbs_rty_o,
   output logic        wbm_cyc_o,
   output logic        wbm_stb_o,
   output logic        wbm_we_o,
   output logic [3:0]  wbm_sel_o,
   output logic [31:0] wbm_adr_o,
   input  logic [31:0] wbm_dat_i,
   input  logic        wbm_ack_i,
   input  logic        wbm_err_i
);
   import sg_dma_pkg::*;

   ctrl_cmd_t   cmd;
   chain_stat_t stat;
   logic        fetch_start;
   logic [31:3] fetch_addr;
   logic        fetch_done;
   logic        fetch_err;
   sg_desc_t    fetch_desc;

   dma_csr_slave u_csr (
      .wb_clk_i (wb_clk_i),  .wb_rst_i (wb_rst_i),
      .wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(wbs_we_i),
      .wbs_sel_i(wbs_sel_i), .wbs_adr_i(wbs_adr_i), .wbs_dat_i(wbs_dat_i),
      .wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o), .wbs_err_o(wbs_err_o),
      .wbs_rty_o(wbs_rty_o), .stat_i(stat), .cmd_o(cmd)
   );

   sg_chain_ctrl u_ctrl (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .cmd_i(cmd), .stat_o(stat),
      .start_o(fetch_start), .addr_o(fetch_addr), .done_i(fetch_done),
      .fetch_err_i(fetch_err), .desc_i(fetch_desc)
   );

   sg_desc_fetch u_fetch (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .start_i(fetch_start),
      .addr_i(fetch_addr), .done_o(fetch_done), .fetch_err_o(fetch_err),
      .busy_o(), .desc_o(fetch_desc),
      .wbm_cyc_o(wbm_cyc_o), .wbm_stb_o(wbm_stb_o), .wbm_we_o(wbm_we_o),
      .wbm_sel_o(wbm_sel_o), .wbm_adr_o(wbm_adr_o), .wbm_dat_i(wbm_dat_i),
      .wbm_ack_i(wbm_ack_i), .wbm_err_i(wbm_err_i)
   );

endmodule

// File: verif/sg_dma_mem.sv
/* testbench memory
   answers wishbone master reads from a word array,
   with a random number of wait states per access */
module sg_dma_mem (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [3:0]  sel_i,
   input  logic [31:0] adr_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] mem [0:255];   // 1 KB, upper address bits alias
   logic [1:0]  wait_q;
   int          seed;

   initial begin
      seed = 32'h7c53_291d;
      for (int i = 0; i < 256; i++)
         mem[i] = 32'hd00d_0000 | i;   // unused words show their own index
   end

   always @(negedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         ack_o  <= 1'b0;
         err_o  <= 1'b0;
         dat_o  <= '0;
         wait_q <= '0;
      end else begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
         if (cyc_i && stb_i && !ack_o && !err_o) begin
            if (we_i || (sel_i != 4'hf)) begin
               err_o <= 1'b1;                 // read only, whole words only
            end else if (wait_q == 2'd0) begin
               ack_o  <= 1'b1;
               dat_o  <= mem[adr_i[9:2]];
               wait_q <= 2'($random(seed));   // waits for the next access
            end else begin
               wait_q <= wait_q - 2'd1;
            end
         end
      end
   end

endmodule

// File: verif/sg_dma_tb.sv
/* sg dma testbench
   register access over the host port, descriptor chains in the
   memory model, reference chain walk and readback checks */
module sg_dma_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import sg_dma_pkg::*;

   localparam int TOTAL_DESC      = 9;   // chain a plus chain b
   localparam int WATCHDOG_CYCLES = TOTAL_DESC * 40 + 2000;

   typedef struct packed {
      sg_desc_t [SLOT_NUM-1:0] slots;
      logic [31:3]             dar;
      logic [31:3]             first;
      logic [31:3]             last;
      logic [31:3]             next_desc;
      logic [SLOT_IDX_W-1:0]   ptr;
   } chain_exp_t;

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        host_cyc, host_stb, host_we, host_ack, host_err, host_rty;
   logic [3:0]  host_sel;
   logic [31:0] host_adr, host_wdat, host_rdat;
   logic        mem_cyc, mem_stb, mem_we, mem_ack, mem_err;
   logic [3:0]  mem_sel;
   logic [31:0] mem_adr, mem_rdat;
   logic [31:0] image [0:255];   // what the reference walks over
   int          errors;
   chain_exp_t  exp_chain;

   sg_dma_top sg_dma_top_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
      .wbs_cyc_i(host_cyc), .wbs_stb_i(host_stb), .wbs_we_i(host_we),
      .wbs_sel_i(host_sel), .wbs_adr_i(host_adr), .wbs_dat_i(host_wdat),
      .wbs_dat_o(host_rdat), .wbs_ack_o(host_ack), .wbs_err_o(host_err),
      .wbs_rty_o(host_rty),
      .wbm_cyc_o(mem_cyc), .wbm_stb_o(mem_stb), .wbm_we_o(mem_we),
      .wbm_sel_o(mem_sel), .wbm_adr_o(mem_adr), .wbm_dat_i(mem_rdat),
      .wbm_ack_i(mem_ack), .wbm_err_i(mem_err)
   );

   sg_dma_mem mem_i (
      .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .cyc_i(mem_cyc), .stb_i(mem_stb),
      .we_i(mem_we), .sel_i(mem_sel), .adr_i(mem_adr), .dat_o(mem_rdat),
      .ack_o(mem_ack), .err_o(mem_err)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #10 wb_clk_i = ~wb_clk_i;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge wb_clk_i);
      $display("watchdog expired after %0d cycles, errors: %0d", WATCHDOG_CYCLES, errors);
      $display("*** FAILED ***");
      $finish;
   end

   // expected walk: slots round robin, dar and last end on the final descriptor
   function automatic chain_exp_t walk_chain(chain_exp_t prev, logic [31:3] start, bit fresh);
      chain_exp_t  e;
      logic [31:3] a;
      sg_desc_t    d;
      int          w;
      bit          stop;
      e    = prev;
      a    = start;
      stop = 1'b0;
      if (fresh)
         e.first = start;
      for (int n = 0; n < 16 && !stop; n++) begin
         w            = {a[9:3], 1'b0};
         d.state      = image[w][7:0];
         d.desc       = image[w+1][15:0];
         d.addr       = image[w+2][31:3];
         d.next       = image[w+3][31:3];
         e.slots[e.ptr] = d;
         e.ptr        = e.ptr + 1'b1;
         e.dar        = a;
         e.last       = a;
         e.next_desc  = d.next;
         stop         = d.state[0] || (d.next == '0);
         a            = d.next;
      end
      return e;
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_desc(input string name, input sg_desc_t exp, input sg_desc_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic bus_cycle(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat,
                            output logic ack, output logic err);
      int n;
      n = 0;
      @(negedge wb_clk_i);
      host_cyc  = 1'b1;
      host_stb  = 1'b1;
      host_we   = we;
      host_sel  = sel;
      host_adr  = adr;
      host_wdat = wdat;
      @(negedge wb_clk_i);
      while (!host_ack && !host_err && n < 16) begin
         @(negedge wb_clk_i);
         n++;
      end
      ack  = host_ack;
      err  = host_err;
      rdat = host_rdat;
      if (!ack && !err) begin
         $display("register slave gave no response at address %h", adr);
         errors++;
      end
      host_cyc = 1'b0;
      host_stb = 1'b0;
      host_we  = 1'b0;
   endtask

   task automatic reg_write(input logic [4:0] idx, input logic [31:0] data);
      logic [31:0] rd;
      logic        ack, err;
      bus_cycle(1'b1, 4'hf, {25'h0, idx, 2'b00}, data, rd, ack, err);
   endtask

   task automatic reg_read(input logic [4:0] idx, output logic [31:0] data);
      logic ack, err;
      bus_cycle(1'b0, 4'hf, {25'h0, idx, 2'b00}, 32'h0, data, ack, err);
   endtask

   // poll csr until the masked bits match
   task automatic wait_csr(input logic [31:0] mask, input logic [31:0] value, input string what);
      logic [31:0] rd;
      int          tries;
      tries = 0;
      rd    = ~value;
      while (((rd & mask) != value) && tries < 100) begin
         reg_read(REG_CSR, rd);
         tries++;
      end
      if ((rd & mask) != value) begin
         $display("engine never reached %s", what);
         errors++;
      end
   endtask

   task automatic compare_chain(input string name, input chain_exp_t e);
      logic [31:0] w [4];
      logic [31:0] rd;
      sg_desc_t    act;
      for (int s = 0; s < SLOT_NUM; s++) begin
         for (int k = 0; k < DESC_WORDS; k++)
            reg_read(5'(4 + 4 * s + k), w[k]);
         act.state = w[0][7:0];
         act.desc  = w[1][15:0];
         act.addr  = w[2][31:3];
         act.next  = w[3][31:3];
         check_desc($sformatf("%s slot %0d", name, s), e.slots[s], act);
      end
      reg_read(REG_DAR, rd);
      check_word({name, " dar"}, {e.dar, 3'b000}, rd);
      reg_read(REG_FIRST, rd);
      check_word({name, " first"}, {e.first, 3'b000}, rd);
      reg_read(REG_LAST, rd);
      check_word({name, " last"}, {e.last, 3'b000}, rd);
      reg_read(REG_NEXT, rd);
      check_word({name, " next"}, {e.next_desc, 3'b000}, rd);
   endtask

   task automatic put_desc(input logic [31:0] a, input logic [7:0] state,
                           input logic [15:0] desc, input logic [31:0] buf_adr,
                           input logic [31:0] next);
      int w;
      w            = a[9:2];
      image[w]     = {24'hcafe00, state};   // junk above the used fields
      image[w + 1] = {16'hbeef, desc};
      image[w + 2] = buf_adr;
      image[w + 3] = next | 32'h5;
      for (int k = 0; k < DESC_WORDS; k++)
         mem_i.mem[w + k] = image[w + k];
   endtask

   initial begin
      logic [31:0] rd;
      logic        ack, err;
      errors    = 0;
      wb_rst_i  = 1'b1;
      host_cyc  = 1'b0;
      host_stb  = 1'b0;
      host_we   = 1'b0;
      host_sel  = 4'h0;
      host_adr  = '0;
      host_wdat = '0;
      exp_chain = '0;
      for (int i = 0; i < 256; i++)
         image[i] = '0;
      repeat (3) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;

      // chain a ends on a zero next, chain b stops on its third entry
      put_desc(32'h100, 8'h10, 16'h0040, 32'h8000_1000, 32'h180);
      put_desc(32'h180, 8'h22, 16'h0080, 32'h8000_2004, 32'h140);
      put_desc(32'h140, 8'h30, 16'h0100, 32'h8000_3000, 32'h000);
      put_desc(32'h200, 8'h40, 16'h0200, 32'h9000_0000, 32'h2a0);
      put_desc(32'h2a0, 8'h52, 16'h0400, 32'h9000_1008, 32'h220);
      put_desc(32'h220, 8'h61, 16'h0800, 32'h9000_2000, 32'h300);
      put_desc(32'h300, 8'h70, 16'h1000, 32'h9000_3000, 32'h260);
      put_desc(32'h260, 8'h80, 16'h2000, 32'h9000_4007, 32'h3e0);
      put_desc(32'h3e0, 8'h90, 16'h4000, 32'h9000_5000, 32'h000);

      for (int i = 0; i <= 5'h16; i++) begin
         reg_read(5'(i), rd);
         check_word($sformatf("reset reg %0d", i), 32'h0, rd);
      end
      check_word("rty low", 32'h0, {31'h0, host_rty});
      bus_cycle(1'b0, 4'b0011, 32'h4, 32'h0, rd, ack, err);
      check_word("partial select ack/err", 32'h1, {30'h0, ack, err});

      reg_write(REG_CCR, 32'h2);
      reg_write(REG_NDAR, 32'h40);
      reg_read(REG_NDAR, rd);
      check_word("ndar locked while enabled", 32'h0, rd);
      reg_write(REG_CCR, 32'h0);
      reg_write(REG_NDAR, 32'h107);
      reg_read(REG_NDAR, rd);
      check_word("ndar write", 32'h107 & ~32'h7, rd);

      reg_write(REG_NDAR, 32'h100);
      reg_write(REG_CCR, 32'h2);
      wait_csr(32'h1, 32'h1, "irq after chain a");
      exp_chain = walk_chain(exp_chain, 29'(32'h100 >> 3), 1'b1);
      compare_chain("chain a", exp_chain);
      reg_read(REG_CSR, rd);
      check_word("chain a csr", 32'h1, rd);
      reg_write(REG_CCR, 32'h6);   // int clear, keep enable
      reg_read(REG_CSR, rd);
      check_word("irq clear", 32'h0, rd);

      reg_write(REG_CCR, 32'h0);
      reg_write(REG_NDAR, 32'h200);
      reg_write(REG_CCR, 32'h2);
      wait_csr(32'h1, 32'h1, "irq at stop bit");
      exp_chain = walk_chain(exp_chain, 29'(32'h200 >> 3), 1'b1);
      compare_chain("chain b stop", exp_chain);
      reg_write(REG_CCR, 32'h6);
      reg_write(REG_CCR, 32'h3);   // resume
      wait_csr(32'h1, 32'h1, "irq after resume");
      exp_chain = walk_chain(exp_chain, exp_chain.next_desc, 1'b0);
      compare_chain("chain b resume", exp_chain);
      reg_read(REG_CCR, rd);
      check_word("resume consumed", 32'h2, rd);

      // drop enable in the middle of a walk
      reg_write(REG_CCR, 32'h6);
      reg_write(REG_CCR, 32'h0);
      reg_write(REG_NDAR, 32'h100);
      reg_write(REG_CCR, 32'h2);
      reg_read(REG_CSR, rd);
      check_word("busy while walking", 32'h2, rd & 32'h2);
      reg_write(REG_CCR, 32'h0);
      wait_csr(32'h2, 32'h0, "busy low after disable");

      $display("checks done, errors: %0d", errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: sg_dma.f
logic/sg_dma_pkg.sv
logic/dma_csr_slave.sv
logic/sg_desc_fetch.sv
logic/sg_chain_ctrl.sv
logic/sg_dma_top.sv
verif/sg_dma_mem.sv
verif/sg_dma_tb.sv

// File: Makefile
# Verilator build and run for the sg dma engine
VERILATOR ?= verilator
TOP       ?= sg_dma_tb
FILELIST  ?= sg_dma.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
